// ==== verilog/proc_defines.svh ====
/*
 * Word width, register count and memory depths of the 16-bit core.
 * Included by the RTL and the testbench; the package holds the types.
 */

`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// data and instruction word
`define PROC_WORD_W 16

// general purpose registers
`define PROC_NUM_REGS 8

// register select width, log2 of the register count
`define PROC_REG_SEL_W 3

// instruction memory depth in words
`define PROC_IMEM_WORDS 256

// data memory depth in words
`define PROC_DMEM_WORDS 256

// opcode field position in the instruction word
`define PROC_OPCODE_HI 15
`define PROC_OPCODE_LO 11

`endif

// ==== verilog/proc_pkg.sv ====
/*
 * Types shared by the decoder, the datapath and the testbench model.
 * Opcodes, alu operations, branch conditions and the decoded control word.
 */

`default_nettype none

package proc_pkg;

    // instruction opcodes, bits 15 to 11
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_J    = 5'b00100,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_BNEZ = 5'b01101,
        OP_BLTZ = 5'b01110,
        OP_BGEZ = 5'b01111,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_SLLI = 5'b10100,
        OP_SRLI = 5'b10111,
        OP_LI   = 5'b11000,
        OP_ADD  = 5'b11001,
        OP_SUB  = 5'b11010,
        OP_AND  = 5'b11011,
        OP_XOR  = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_XOR    = 3'd3,
        ALU_SLL    = 3'd4,
        ALU_SRL    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // compare-with-zero on the first source register
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQZ  = 3'd1,
        BR_NEZ  = 3'd2,
        BR_LTZ  = 3'd3,
        BR_GEZ  = 3'd4
    } branch_cond_e;

    // which instruction field feeds the immediate
    typedef enum logic [1:0] {
        IMM_5  = 2'd0,
        IMM_8  = 2'd1,
        IMM_11 = 2'd2
    } imm_kind_e;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         alu_src_imm;
        imm_kind_e    imm_kind;
        logic         reg_write;
        logic         wb_from_mem;
        logic         mem_write;
        branch_cond_e branch_cond;
        logic         jump;
        logic         halt;
        logic         illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/mem_if.sv ====
/*
 * One memory access port. The requester drives the request, the memory
 * returns rdata combinationally from addr; writes land on the clock edge.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

interface mem_if;

    logic                    en;
    logic                    wr;
    logic [`PROC_WORD_W-1:0] addr;
    logic [`PROC_WORD_W-1:0] wdata;
    logic [`PROC_WORD_W-1:0] rdata;

    modport requester (
        output en,
        output wr,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  en,
        input  wr,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== verilog/control.sv ====
/*
 * Instruction decoder. Purely combinational from the instruction word to
 * the control struct; undefined opcodes raise illegal with all enables low.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module control (
    input  wire [`PROC_WORD_W-1:0] instr,
    output proc_pkg::ctrl_t        ctrl
);

    proc_pkg::opcode_e opcode;

    assign opcode = proc_pkg::opcode_e'(instr[`PROC_OPCODE_HI:`PROC_OPCODE_LO]);

    always_comb begin
        // everything off unless the opcode turns it on
        ctrl = '0;
        case (opcode)
            proc_pkg::OP_HALT: begin
                ctrl.halt = 1'b1;
            end
            proc_pkg::OP_ADD, proc_pkg::OP_SUB,
            proc_pkg::OP_AND, proc_pkg::OP_XOR: begin
                ctrl.reg_write = 1'b1;
                case (opcode)
                    proc_pkg::OP_SUB: ctrl.alu_op = proc_pkg::ALU_SUB;
                    proc_pkg::OP_AND: ctrl.alu_op = proc_pkg::ALU_AND;
                    proc_pkg::OP_XOR: ctrl.alu_op = proc_pkg::ALU_XOR;
                    default:          ctrl.alu_op = proc_pkg::ALU_ADD;
                endcase
            end
            proc_pkg::OP_ADDI: begin
                ctrl.alu_op      = proc_pkg::ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = proc_pkg::IMM_5;
                ctrl.reg_write   = 1'b1;
            end
            proc_pkg::OP_LI: begin
                ctrl.alu_op      = proc_pkg::ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = proc_pkg::IMM_8;
                ctrl.reg_write   = 1'b1;
            end
            proc_pkg::OP_SLLI, proc_pkg::OP_SRLI: begin
                // shift amount rides in the low four bits of imm5
                ctrl.alu_op      = (opcode == proc_pkg::OP_SLLI) ?
                                   proc_pkg::ALU_SLL : proc_pkg::ALU_SRL;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = proc_pkg::IMM_5;
                ctrl.reg_write   = 1'b1;
            end
            proc_pkg::OP_LD: begin
                ctrl.alu_op      = proc_pkg::ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = proc_pkg::IMM_5;
                ctrl.reg_write   = 1'b1;
                ctrl.wb_from_mem = 1'b1;
            end
            proc_pkg::OP_ST: begin
                ctrl.alu_op      = proc_pkg::ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = proc_pkg::IMM_5;
                ctrl.mem_write   = 1'b1;
            end
            proc_pkg::OP_BEQZ: begin
                ctrl.imm_kind    = proc_pkg::IMM_8;
                ctrl.branch_cond = proc_pkg::BR_EQZ;
            end
            proc_pkg::OP_BNEZ: begin
                ctrl.imm_kind    = proc_pkg::IMM_8;
                ctrl.branch_cond = proc_pkg::BR_NEZ;
            end
            proc_pkg::OP_BLTZ: begin
                ctrl.imm_kind    = proc_pkg::IMM_8;
                ctrl.branch_cond = proc_pkg::BR_LTZ;
            end
            proc_pkg::OP_BGEZ: begin
                ctrl.imm_kind    = proc_pkg::IMM_8;
                ctrl.branch_cond = proc_pkg::BR_GEZ;
            end
            proc_pkg::OP_J: begin
                ctrl.imm_kind = proc_pkg::IMM_11;
                ctrl.jump     = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
/*
 * Arithmetic, logic and shift unit of the single-cycle core.
 * The zero and negative flags look at operand a for the branches.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module alu (
    input  wire [`PROC_WORD_W-1:0] a,
    input  wire [`PROC_WORD_W-1:0] b,
    input  proc_pkg::alu_op_e      op,
    output logic [`PROC_WORD_W-1:0] result,
    output logic                    zero,
    output logic                    negative
);

    localparam int SHAMT_W = $clog2(`PROC_WORD_W);

    logic [SHAMT_W-1:0] shamt;

    // shift amount from the low bits of b
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            proc_pkg::ALU_ADD:    result = a + b;
            proc_pkg::ALU_SUB:    result = a - b;
            proc_pkg::ALU_AND:    result = a & b;
            proc_pkg::ALU_XOR:    result = a ^ b;
            proc_pkg::ALU_SLL:    result = a << shamt;
            proc_pkg::ALU_SRL:    result = a >> shamt;
            proc_pkg::ALU_PASS_B: result = b;
            default:              result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch flags, taken from the first source register
    //////////////////////////////////////////////////////////////////////

    assign zero     = (a == '0);
    assign negative = a[`PROC_WORD_W-1];

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
/*
 * Eight-entry register file, two combinational reads and one write.
 * A write is held in a staging register for a cycle and reads forward it.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module reg_file (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire [`PROC_REG_SEL_W-1:0]  rd_sel_a,
    input  wire [`PROC_REG_SEL_W-1:0]  rd_sel_b,
    input  wire [`PROC_REG_SEL_W-1:0]  wr_sel,
    input  wire [`PROC_WORD_W-1:0]     wr_data,
    input  wire                        wr_en,
    output logic [`PROC_WORD_W-1:0]    rd_data_a,
    output logic [`PROC_WORD_W-1:0]    rd_data_b
);

    logic [`PROC_WORD_W-1:0]    regs [`PROC_NUM_REGS];
    logic                       stage_valid;
    logic [`PROC_REG_SEL_W-1:0] stage_sel;
    logic [`PROC_WORD_W-1:0]    stage_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PROC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            stage_valid <= 1'b0;
            stage_sel   <= '0;
            stage_data  <= '0;
        end else begin
            // capture this cycle's write, retire last cycle's into the array
            stage_valid <= wr_en;
            stage_sel   <= wr_sel;
            stage_data  <= wr_data;
            if (stage_valid) begin
                regs[stage_sel] <= stage_data;
            end
        end
    end

    // bypass the staged write, newest value wins
    assign rd_data_a = (stage_valid && stage_sel == rd_sel_a) ? stage_data : regs[rd_sel_a];
    assign rd_data_b = (stage_valid && stage_sel == rd_sel_b) ? stage_data : regs[rd_sel_b];

endmodule

`default_nettype wire

// ==== verilog/memory.sv ====
/*
 * Word-addressed memory behind a mem_if port, used for instructions and data.
 * Reads are combinational, writes happen on the rising edge with en and wr.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module memory #(
    parameter int DEPTH_WORDS = `PROC_IMEM_WORDS
) (
    input  wire   clk,
    input  wire   arst_n,
    mem_if.memory port
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic [`PROC_WORD_W-1:0] mem [DEPTH_WORDS];
    logic [IDX_W-1:0]        idx;

    // address wraps at the depth
    assign idx = IDX_W'(port.addr % DEPTH_WORDS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (port.en && port.wr) begin
            mem[idx] <= port.wdata;
        end
    end

    assign port.rdata = mem[idx];

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
/*
 * Program counter and next-pc selection with the branch decision.
 * Also holds the sticky halted and err state that stops the core.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module fetch (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     run,
    input  wire proc_pkg::ctrl_t    ctrl,
    input  wire                     a_zero,
    input  wire                     a_negative,
    input  wire [`PROC_WORD_W-1:0]  offset,
    output logic [`PROC_WORD_W-1:0] pc,
    output logic                    active,
    output logic                    halted,
    output logic                    err
);

    logic [`PROC_WORD_W-1:0] pc_plus2;
    logic [`PROC_WORD_W-1:0] target;
    logic [`PROC_WORD_W-1:0] next_pc;
    logic                    taken;
    logic                    stop;

    assign pc_plus2 = pc + `PROC_WORD_W'(2);
    // offset counts words, pc counts bytes
    assign target   = pc_plus2 + {offset[`PROC_WORD_W-2:0], 1'b0};
    assign stop     = ctrl.halt | ctrl.illegal;

    always_comb begin
        case (ctrl.branch_cond)
            proc_pkg::BR_EQZ: taken = a_zero;
            proc_pkg::BR_NEZ: taken = !a_zero;
            proc_pkg::BR_LTZ: taken = a_negative;
            proc_pkg::BR_GEZ: taken = !a_negative;
            default:          taken = 1'b0;
        endcase
        if (ctrl.jump) begin
            taken = 1'b1;
        end
    end

    // pc parks on the stopping instruction
    assign next_pc = stop ? pc : (taken ? target : pc_plus2);
    assign active  = run && !halted;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (active) begin
            pc <= next_pc;
            if (stop) begin
                halted <= 1'b1;
            end
            if (ctrl.illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/proc.sv ====
/*
 * Top of the 16-bit single-cycle core. Load the program through the load
 * port with run low, then raise run; watch the writeback trace and halted.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module proc (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         run,
    input  wire                         load_en,
    input  wire [`PROC_WORD_W-1:0]      load_addr,
    input  wire [`PROC_WORD_W-1:0]      load_data,
    output logic                        wb_valid,
    output logic [`PROC_REG_SEL_W-1:0]  wb_reg,
    output logic [`PROC_WORD_W-1:0]     wb_data,
    output logic                        halted,
    output logic                        err
);

    localparam int W = `PROC_WORD_W;

    logic [W-1:0]                instr;
    logic [W-1:0]                pc;
    logic [W-1:0]                rd_a;
    logic [W-1:0]                rd_b;
    logic [W-1:0]                imm_ext;
    logic [W-1:0]                alu_b;
    logic [W-1:0]                alu_result;
    logic [W-1:0]                wb_value;
    logic [`PROC_REG_SEL_W-1:0]  wr_sel;
    logic                        reg_we;
    logic                        a_zero;
    logic                        a_negative;
    logic                        active;
    proc_pkg::ctrl_t             ctrl;

    mem_if imem_bus ();
    mem_if dmem_bus ();

    //////////////////////////////////////////////////////////////////////
    // instruction side
    //////////////////////////////////////////////////////////////////////

    // load port owns the instruction memory while run is low
    assign imem_bus.en    = run ? 1'b1 : load_en;
    assign imem_bus.wr    = run ? 1'b0 : load_en;
    assign imem_bus.addr  = run ? {1'b0, pc[W-1:1]} : load_addr;
    assign imem_bus.wdata = load_data;
    assign instr          = imem_bus.rdata;

    memory #(.DEPTH_WORDS(`PROC_IMEM_WORDS)) i_imem (.clk(clk), .arst_n(arst_n), .port(imem_bus));

    control i_control (.instr(instr), .ctrl(ctrl));

    fetch i_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .ctrl       (ctrl),
        .a_zero     (a_zero),
        .a_negative (a_negative),
        .offset     (imm_ext),
        .pc         (pc),
        .active     (active),
        .halted     (halted),
        .err        (err)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.imm_kind)
            proc_pkg::IMM_8:  imm_ext = {{(W-8){instr[7]}}, instr[7:0]};
            proc_pkg::IMM_11: imm_ext = {{(W-11){instr[10]}}, instr[10:0]};
            default:          imm_ext = {{(W-5){instr[4]}}, instr[4:0]};
        endcase
    end

    // li writes rs field, other immediates write [7:5], r-type writes [4:2]
    always_comb begin
        if (ctrl.imm_kind == proc_pkg::IMM_8) begin
            wr_sel = instr[10:8];
        end else if (ctrl.alu_src_imm) begin
            wr_sel = instr[7:5];
        end else begin
            wr_sel = instr[4:2];
        end
    end

    reg_file i_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_sel_a  (instr[10:8]),
        .rd_sel_b  (instr[7:5]),
        .wr_sel    (wr_sel),
        .wr_data   (wb_value),
        .wr_en     (reg_we),
        .rd_data_a (rd_a),
        .rd_data_b (rd_b)
    );

    assign alu_b = ctrl.alu_src_imm ? imm_ext : rd_b;

    alu i_alu (
        .a        (rd_a),
        .b        (alu_b),
        .op       (ctrl.alu_op),
        .result   (alu_result),
        .zero     (a_zero),
        .negative (a_negative)
    );

    // data memory is word addressed by the alu sum
    assign dmem_bus.en    = active && (ctrl.mem_write || ctrl.wb_from_mem);
    assign dmem_bus.wr    = active && ctrl.mem_write;
    assign dmem_bus.addr  = alu_result;
    assign dmem_bus.wdata = rd_b;

    memory #(.DEPTH_WORDS(`PROC_DMEM_WORDS)) i_dmem (.clk(clk), .arst_n(arst_n), .port(dmem_bus));

    assign wb_value = ctrl.wb_from_mem ? dmem_bus.rdata : alu_result;
    assign reg_we   = active && ctrl.reg_write;

    // trace port mirrors the register write
    assign wb_valid = reg_we;
    assign wb_reg   = wr_sel;
    assign wb_data  = wb_value;

endmodule

`default_nettype wire

// ==== verification/proc_tb_model.svh ====
/*
 * Reference side of the core testbench: LFSR stimulus, instruction encoders
 * and an instruction-set model that queues the expected writebacks.
 * Included inside the testbench module, after proc_defines.svh.
 */

`ifndef PROC_TB_MODEL_SVH
`define PROC_TB_MODEL_SVH

logic [31:0]                lfsr_state;
logic [`PROC_WORD_W-1:0]    prog [`PROC_IMEM_WORDS];
int                         prog_len;
logic [`PROC_WORD_W-1:0]    model_regs [`PROC_NUM_REGS];
logic [`PROC_WORD_W-1:0]    model_dmem [`PROC_DMEM_WORDS];
logic [`PROC_REG_SEL_W-1:0] exp_reg [$];
logic [`PROC_WORD_W-1:0]    exp_data [$];

// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[14:0], lfsr_state[0]};
    end
    return v;
endfunction

//////////////////////////////////////////////////////////////////////
// instruction formats
//////////////////////////////////////////////////////////////////////

// r-type: sources in [10:8] and [7:5], destination in [4:2]
function automatic logic [15:0] reg_instr(input logic [4:0] op, input logic [2:0] ra,
                                          input logic [2:0] rb, input logic [2:0] rd);
    return {op, ra, rb, rd, 2'b00};
endfunction

// addi, shifts, ld and st: base in [10:8], dest or store data in [7:5]
function automatic logic [15:0] imm5_instr(input logic [4:0] op, input logic [2:0] ra,
                                           input logic [2:0] rd, input logic [4:0] imm);
    return {op, ra, rd, imm};
endfunction

// li and the branches
function automatic logic [15:0] imm8_instr(input logic [4:0] op, input logic [2:0] r,
                                           input logic [7:0] imm);
    return {op, r, imm};
endfunction

function automatic logic [15:0] jump_instr(input logic [10:0] off);
    return {proc_pkg::OP_J, off};
endfunction

task automatic clear_program();
    for (int i = 0; i < `PROC_IMEM_WORDS; i++) begin
        prog[i] = '0;
    end
    prog_len = 0;
endtask

task automatic emit(input logic [15:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

task automatic expect_write(input logic [`PROC_REG_SEL_W-1:0] r,
                            input logic [`PROC_WORD_W-1:0] v);
    model_regs[r] = v;
    exp_reg.push_back(r);
    exp_data.push_back(v);
endtask

//////////////////////////////////////////////////////////////////////
// instruction-set model, runs prog from pc 0 until halt or illegal
//////////////////////////////////////////////////////////////////////

task automatic run_model();
    logic [15:0] pc;
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm5;
    logic [15:0] imm8;
    logic [15:0] imm11;
    logic [15:0] next_pc;
    logic        stop;
    int          steps;
    for (int i = 0; i < `PROC_NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < `PROC_DMEM_WORDS; i++) begin
        model_dmem[i] = '0;
    end
    exp_reg.delete();
    exp_data.delete();
    pc    = '0;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < 4 * `PROC_IMEM_WORDS) begin
        ins     = prog[(pc >> 1) % `PROC_IMEM_WORDS];
        a       = model_regs[ins[10:8]];
        b       = model_regs[ins[7:5]];
        imm5    = {{11{ins[4]}}, ins[4:0]};
        imm8    = {{8{ins[7]}}, ins[7:0]};
        imm11   = {{5{ins[10]}}, ins[10:0]};
        next_pc = pc + 16'd2;
        case (ins[15:11])
            proc_pkg::OP_LI:   expect_write(ins[10:8], imm8);
            proc_pkg::OP_ADD:  expect_write(ins[4:2], a + b);
            proc_pkg::OP_SUB:  expect_write(ins[4:2], a - b);
            proc_pkg::OP_AND:  expect_write(ins[4:2], a & b);
            proc_pkg::OP_XOR:  expect_write(ins[4:2], a ^ b);
            proc_pkg::OP_ADDI: expect_write(ins[7:5], a + imm5);
            proc_pkg::OP_SLLI: expect_write(ins[7:5], a << ins[3:0]);
            proc_pkg::OP_SRLI: expect_write(ins[7:5], a >> ins[3:0]);
            proc_pkg::OP_LD:   expect_write(ins[7:5], model_dmem[(a + imm5) % `PROC_DMEM_WORDS]);
            proc_pkg::OP_ST:   model_dmem[(a + imm5) % `PROC_DMEM_WORDS] = b;
            proc_pkg::OP_BEQZ: if (a == '0) next_pc = next_pc + (imm8 << 1);
            proc_pkg::OP_BNEZ: if (a != '0) next_pc = next_pc + (imm8 << 1);
            proc_pkg::OP_BLTZ: if (a[15]) next_pc = next_pc + (imm8 << 1);
            proc_pkg::OP_BGEZ: if (!a[15]) next_pc = next_pc + (imm8 << 1);
            proc_pkg::OP_J:    next_pc = next_pc + (imm11 << 1);
            // halt and every undefined opcode stop the core
            default:           stop = 1'b1;
        endcase
        pc = next_pc;
        steps++;
    end
endtask

`endif

// ==== verification/tb_proc.sv ====
/*
 * Testbench for the 16-bit single-cycle core. Each test resets the core,
 * loads a program through the load port, raises run and checks the
 * writeback trace and the stop state against the reference model.
 */

`timescale 1ns/1ps
`default_nettype none

`include "proc_defines.svh"

module tb_proc;

    localparam int ARITH_LEN   = 33;
    localparam int MEM_LEN     = 20;
    localparam int BRANCH_LEN  = 25;
    localparam int JUMP_LEN    = 7;
    localparam int HALT_LEN    = 3;
    localparam int ILLEGAL_LEN = 3;
    localparam int TOTAL_INSTR = ARITH_LEN + MEM_LEN + BRANCH_LEN + JUMP_LEN
                               + HALT_LEN + ILLEGAL_LEN;
    localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR + 100;

    logic                       clk;
    logic                       arst_n;
    logic                       run;
    logic                       load_en;
    logic [`PROC_WORD_W-1:0]    load_addr;
    logic [`PROC_WORD_W-1:0]    load_data;
    logic                       wb_valid;
    logic [`PROC_REG_SEL_W-1:0] wb_reg;
    logic [`PROC_WORD_W-1:0]    wb_data;
    logic                       halted;
    logic                       err;

    string test_name;
    int    cycle_count;

    `include "proc_tb_model.svh"

    proc i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            report_failure($sformatf("timeout: run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // trace checking, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    task automatic check_writeback();
        logic [`PROC_REG_SEL_W-1:0] r;
        logic [`PROC_WORD_W-1:0]    d;
        assert (exp_reg.size() > 0)
            else report_failure($sformatf("%s: writeback to r%0d that the model never made",
                                          test_name, wb_reg));
        r = exp_reg.pop_front();
        d = exp_data.pop_front();
        assert (wb_reg == r)
            else report_failure($sformatf("error: %s wb_reg expected %0d actual %0d",
                                          test_name, r, wb_reg));
        assert (wb_data == d)
            else report_failure($sformatf("error: %s wb_data expected %h actual %h",
                                          test_name, d, wb_data));
    endtask

    always @(negedge clk) begin
        if (wb_valid) begin
            check_writeback();
        end
        assert (!wb_valid || (run && !halted))
            else report_failure($sformatf("%s: writeback while the core was stopped",
                                          test_name));
    end

    //////////////////////////////////////////////////////////////////////
    // test sequencing
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= `PROC_WORD_W'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // stopped state must hold for a few cycles after it appears
    task automatic wait_for_stop(input logic err_expected);
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
        repeat (4) begin
            assert (halted)
                else report_failure($sformatf("%s: halted dropped after the core stopped",
                                              test_name));
            assert (err == err_expected)
                else report_failure($sformatf("error: %s err expected %0d actual %0d",
                                              test_name, err_expected, err));
            @(negedge clk);
        end
    endtask

    task automatic run_test(input string name, input logic err_expected);
        test_name = name;
        run_model();
        apply_reset();
        load_program();
        @(posedge clk);
        run <= 1'b1;
        wait_for_stop(err_expected);
        assert (exp_reg.size() == 0)
            else report_failure($sformatf("%s: %0d expected writebacks never appeared",
                                          test_name, exp_reg.size()));
        @(posedge clk);
        run <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // program builders
    //////////////////////////////////////////////////////////////////////

    task automatic arith_program();
        logic [2:0] ra;
        logic [2:0] rd;
        logic [2:0] last;
        logic [2:0] kind;
        clear_program();
        for (int r = 0; r < `PROC_NUM_REGS; r++) begin
            emit(imm8_instr(proc_pkg::OP_LI, 3'(r), 8'(rand_bits(8))));
        end
        last = 3'd0;
        for (int i = 0; i < 24; i++) begin
            // odd slots read the previous result through the bypass
            ra   = (i % 2 == 1) ? last : 3'(rand_bits(3));
            rd   = 3'(rand_bits(3));
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0: emit(reg_instr(proc_pkg::OP_ADD, ra, 3'(rand_bits(3)), rd));
                3'd1: emit(reg_instr(proc_pkg::OP_SUB, ra, 3'(rand_bits(3)), rd));
                3'd2: emit(reg_instr(proc_pkg::OP_AND, ra, 3'(rand_bits(3)), rd));
                3'd3: emit(reg_instr(proc_pkg::OP_XOR, ra, 3'(rand_bits(3)), rd));
                3'd4: emit(imm5_instr(proc_pkg::OP_ADDI, ra, rd, 5'(rand_bits(5))));
                3'd5: emit(imm5_instr(proc_pkg::OP_SLLI, ra, rd, 5'(rand_bits(4))));
                3'd6: emit(imm5_instr(proc_pkg::OP_SRLI, ra, rd, 5'(rand_bits(4))));
                default: emit(imm8_instr(proc_pkg::OP_LI, rd, 8'(rand_bits(8))));
            endcase
            last = rd;
        end
        emit(imm8_instr(proc_pkg::OP_HALT, 3'd0, 8'd0));
    endtask

    task automatic memory_program();
        logic [4:0] offs [6];
        clear_program();
        // r1 holds a positive base
        emit(imm8_instr(proc_pkg::OP_LI, 3'd1, {1'b0, 7'(rand_bits(7))}));
        for (int k = 0; k < 6; k++) begin
            offs[k] = 5'(rand_bits(5));
            emit(imm8_instr(proc_pkg::OP_LI, 3'd2, 8'(rand_bits(8))));
            emit(imm5_instr(proc_pkg::OP_ST, 3'd1, 3'd2, offs[k]));
        end
        for (int k = 0; k < 6; k++) begin
            emit(imm5_instr(proc_pkg::OP_LD, 3'd1, 3'(3 + k % 5), offs[k]));
        end
        emit(imm8_instr(proc_pkg::OP_HALT, 3'd0, 8'd0));
    endtask

    task automatic branch_program();
        logic [4:0] op;
        logic [7:0] val;
        logic       take;
        clear_program();
        for (int c = 0; c < 8; c++) begin
            take = c[0];
            val  = 8'(rand_bits(8));
            case (c / 2)
                0: begin
                    op  = proc_pkg::OP_BEQZ;
                    val = take ? 8'h00 : (val | 8'h01);
                end
                1: begin
                    op  = proc_pkg::OP_BNEZ;
                    val = take ? (val | 8'h01) : 8'h00;
                end
                2: begin
                    op  = proc_pkg::OP_BLTZ;
                    val = take ? (val | 8'h80) : (val & 8'h7f);
                end
                default: begin
                    op  = proc_pkg::OP_BGEZ;
                    val = take ? (val & 8'h7f) : (val | 8'h80);
                end
            endcase
            emit(imm8_instr(proc_pkg::OP_LI, 3'd1, val));
            // offset of one word skips the following li
            emit(imm8_instr(op, 3'd1, 8'd1));
            emit(imm8_instr(proc_pkg::OP_LI, 3'd2, 8'(rand_bits(8))));
        end
        emit(imm8_instr(proc_pkg::OP_HALT, 3'd0, 8'd0));
    endtask

    task automatic jump_program();
        clear_program();
        emit(imm8_instr(proc_pkg::OP_LI, 3'd1, 8'(rand_bits(8))));
        emit(jump_instr(11'd3));
        emit(imm8_instr(proc_pkg::OP_LI, 3'd2, 8'(rand_bits(8))));
        emit(imm8_instr(proc_pkg::OP_LI, 3'd3, 8'(rand_bits(8))));
        emit(imm8_instr(proc_pkg::OP_LI, 3'd4, 8'(rand_bits(8))));
        emit(imm8_instr(proc_pkg::OP_LI, 3'd5, 8'(rand_bits(8))));
        emit(imm8_instr(proc_pkg::OP_HALT, 3'd0, 8'd0));
    endtask

    task automatic halt_program();
        clear_program();
        emit(imm8_instr(proc_pkg::OP_LI, 3'd1, 8'(rand_bits(8))));
        emit(imm8_instr(proc_pkg::OP_HALT, 3'd0, 8'd0));
        emit(imm8_instr(proc_pkg::OP_LI, 3'd2, 8'(rand_bits(8))));
    endtask

    task automatic illegal_program();
        clear_program();
        emit(imm8_instr(proc_pkg::OP_LI, 3'd1, 8'(rand_bits(8))));
        // opcode 00001 is not defined
        emit({5'b00001, 11'(rand_bits(11))});
        emit(imm8_instr(proc_pkg::OP_LI, 3'd2, 8'(rand_bits(8))));
    endtask

    initial begin
        lfsr_state  = 32'h9002;
        cycle_count = 0;
        test_name   = "init";
        arst_n      <= 1'b0;
        run         <= 1'b0;
        load_en     <= 1'b0;
        load_addr   <= '0;
        load_data   <= '0;
        arith_program();
        run_test("arith", 1'b0);
        memory_program();
        run_test("memory", 1'b0);
        branch_program();
        run_test("branch", 1'b0);
        jump_program();
        run_test("jump", 1'b0);
        halt_program();
        run_test("halt", 1'b0);
        illegal_program();
        run_test("illegal", 1'b1);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
+incdir+verification
verilog/proc_pkg.sv
verilog/mem_if.sv
verilog/control.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/memory.sv
verilog/fetch.sv
verilog/proc.sv
verification/tb_proc.sv
